// File: hw/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

  // Datapath and register index
  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 4;
  // NZCV
  localparam int FLAGS_W    = 4;
  // Word index into the data memory
  localparam int MEM_ADDR_W = 4;
  localparam int BRANCH_W   = 24;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [FLAGS_W-1:0]    flags_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [BRANCH_W-1:0]   branch_target_t;

endpackage

`default_nettype wire

// File: hw/arm_isa_pkg.sv
`default_nettype none

package arm_isa_pkg;

  // Field positions in the instruction word
  localparam int COND_LSB   = 28;
  localparam int CLASS_LSB  = 25;
  localparam int OPCODE_LSB = 21;
  localparam int S_BIT      = 20;
  localparam int U_BIT      = 23;
  localparam int RN_LSB     = 16;
  localparam int RD_LSB     = 12;
  localparam int RM_LSB     = 0;
  localparam int ROT_LSB    = 8;
  // Shift type, amount sits two bits above
  localparam int SHIFT_LSB  = 5;

  typedef enum logic [2:0] {
    CLS_DP_REG = 3'b000,
    CLS_DP_IMM = 3'b001,
    CLS_LDST   = 3'b010,
    CLS_BRANCH = 3'b101
  } inst_class_e;

  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB,
    OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN,
    OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } alu_op_e;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_e;

  typedef enum logic [1:0] {
    SH_LSL, SH_LSR, SH_ASR, SH_ROR
  } shift_e;

endpackage

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file #(
  parameter int NUM_REGS = 16
) (
    input  wire                      clk_i
  , input  wire                      reset_i
  , input  wire core_cfg_pkg::reg_addr_t rs1_addr_i
  , input  wire core_cfg_pkg::reg_addr_t rs2_addr_i
  , output core_cfg_pkg::word_t      rs1_data_o
  , output core_cfg_pkg::word_t      rs2_data_o
  , input  wire                      wr_en_i
  , input  wire core_cfg_pkg::reg_addr_t wr_addr_i
  , input  wire core_cfg_pkg::word_t wr_data_i
);

  core_cfg_pkg::word_t regs [NUM_REGS];

  // Old value on a same-cycle write, execute forwards around it
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/operand2_unit.sv
`timescale 1ns/1ps
`default_nettype none

module operand2_unit (
    input  wire core_cfg_pkg::word_t inst_i
  , input  wire core_cfg_pkg::word_t rm_i
  , output core_cfg_pkg::word_t      operand2_o
);

  arm_isa_pkg::inst_class_e inst_class;
  arm_isa_pkg::shift_e      shift_type;
  logic [4:0]               shift_amt;
  logic [4:0]               rot_amt;
  logic [63:0]              imm_pair;
  logic [63:0]              rm_pair;

  assign inst_class = arm_isa_pkg::inst_class_e'(inst_i[arm_isa_pkg::CLASS_LSB +: 3]);
  assign shift_type = arm_isa_pkg::shift_e'(inst_i[arm_isa_pkg::SHIFT_LSB +: 2]);
  assign shift_amt  = inst_i[arm_isa_pkg::SHIFT_LSB + 2 +: 5];

  // Rotate right by twice the 4-bit field
  assign rot_amt  = {inst_i[arm_isa_pkg::ROT_LSB +: 4], 1'b0};
  assign imm_pair = {2{24'd0, inst_i[7:0]}};
  assign rm_pair  = {rm_i, rm_i};

  always_comb begin
    operand2_o = '0;
    case (inst_class)
      arm_isa_pkg::CLS_DP_IMM: begin
        operand2_o = core_cfg_pkg::word_t'(imm_pair >> rot_amt);
      end
      arm_isa_pkg::CLS_DP_REG: begin
        // Amount zero passes Rm through for every type
        case (shift_type)
          arm_isa_pkg::SH_LSL: operand2_o = rm_i << shift_amt;
          arm_isa_pkg::SH_LSR: operand2_o = rm_i >> shift_amt;
          arm_isa_pkg::SH_ASR: operand2_o = $signed(rm_i) >>> shift_amt;
          default:             operand2_o = core_cfg_pkg::word_t'(rm_pair >> shift_amt);
        endcase
      end
      arm_isa_pkg::CLS_LDST: begin
        operand2_o = {20'd0, inst_i[11:0]};
      end
      default: begin
        operand2_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  wire                         clk_i
  , input  wire                         reset_i
  , input  wire arm_isa_pkg::alu_op_e   op_i
  , input  wire core_cfg_pkg::word_t    a_i
  , input  wire core_cfg_pkg::word_t    b_i
  , input  wire arm_isa_pkg::cond_e     cond_i
  , input  wire                         set_flags_i
  , input  wire                         update_i
  , output core_cfg_pkg::word_t         result_o
  , output logic                        cond_met_o
  , output core_cfg_pkg::flags_t        flags_o
);

  localparam int W = core_cfg_pkg::WORD_W;

  logic                flag_n, flag_z, flag_c, flag_v;
  core_cfg_pkg::word_t add_x, add_y;
  logic                add_cin;
  logic [W:0]          sum;
  logic                is_arith;
  logic                ovf;

  assign {flag_n, flag_z, flag_c, flag_v} = flags_o;

  // ********************************************************
  // Condition field
  // ********************************************************
  always_comb begin
    case (cond_i)
      arm_isa_pkg::COND_EQ: cond_met_o = flag_z;
      arm_isa_pkg::COND_NE: cond_met_o = !flag_z;
      arm_isa_pkg::COND_CS: cond_met_o = flag_c;
      arm_isa_pkg::COND_CC: cond_met_o = !flag_c;
      arm_isa_pkg::COND_MI: cond_met_o = flag_n;
      arm_isa_pkg::COND_PL: cond_met_o = !flag_n;
      arm_isa_pkg::COND_VS: cond_met_o = flag_v;
      arm_isa_pkg::COND_VC: cond_met_o = !flag_v;
      arm_isa_pkg::COND_HI: cond_met_o = flag_c && !flag_z;
      arm_isa_pkg::COND_LS: cond_met_o = !flag_c || flag_z;
      arm_isa_pkg::COND_GE: cond_met_o = flag_n == flag_v;
      arm_isa_pkg::COND_LT: cond_met_o = flag_n != flag_v;
      arm_isa_pkg::COND_GT: cond_met_o = !flag_z && (flag_n == flag_v);
      arm_isa_pkg::COND_LE: cond_met_o = flag_z || (flag_n != flag_v);
      arm_isa_pkg::COND_AL: cond_met_o = 1'b1;
      default:              cond_met_o = 1'b0;
    endcase
  end

  // ********************************************************
  // Shared adder, subtracts by inverting one side
  // ********************************************************
  always_comb begin
    add_x    = a_i;
    add_y    = b_i;
    add_cin  = 1'b0;
    is_arith = 1'b1;
    case (op_i)
      arm_isa_pkg::OP_SUB, arm_isa_pkg::OP_CMP: begin
        add_y   = ~b_i;
        add_cin = 1'b1;
      end
      arm_isa_pkg::OP_RSB: begin
        add_x   = b_i;
        add_y   = ~a_i;
        add_cin = 1'b1;
      end
      arm_isa_pkg::OP_ADC: add_cin = flag_c;
      arm_isa_pkg::OP_SBC: begin
        add_y   = ~b_i;
        add_cin = flag_c;
      end
      arm_isa_pkg::OP_RSC: begin
        add_x   = b_i;
        add_y   = ~a_i;
        add_cin = flag_c;
      end
      arm_isa_pkg::OP_ADD, arm_isa_pkg::OP_CMN: add_cin = 1'b0;
      default: is_arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {{W{1'b0}}, add_cin};
  assign ovf = (add_x[W-1] == add_y[W-1]) && (sum[W-1] != add_x[W-1]);

  always_comb begin
    case (op_i)
      arm_isa_pkg::OP_AND, arm_isa_pkg::OP_TST: result_o = a_i & b_i;
      arm_isa_pkg::OP_EOR, arm_isa_pkg::OP_TEQ: result_o = a_i ^ b_i;
      arm_isa_pkg::OP_ORR: result_o = a_i | b_i;
      arm_isa_pkg::OP_MOV: result_o = b_i;
      arm_isa_pkg::OP_BIC: result_o = a_i & ~b_i;
      arm_isa_pkg::OP_MVN: result_o = ~b_i;
      default:             result_o = sum[W-1:0];
    endcase
  end

  // Logical ops leave C and V alone
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_o <= '0;
    end else if (update_i && set_flags_i && cond_met_o) begin
      flags_o <= {result_o[W-1], result_o == '0,
                  is_arith ? sum[W] : flag_c,
                  is_arith ? ovf : flag_v};
    end
  end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                             clk_i
  , input  wire                             reset_i
  , input  wire core_cfg_pkg::word_t        inst_i
  , input  wire                             valid_i
  , input  wire core_cfg_pkg::word_t        rn_data_i
  , input  wire core_cfg_pkg::word_t        rm_data_i
  , input  wire                             wb_en_i
  , input  wire core_cfg_pkg::reg_addr_t    wb_addr_i
  , input  wire core_cfg_pkg::word_t        wb_data_i
  , output logic                            stall_o
  , output logic                            ex_valid_o
  , output logic                            ex_is_load_o
  , output logic                            ex_is_store_o
  , output logic                            ex_write_o
  , output core_cfg_pkg::reg_addr_t         ex_rd_addr_o
  , output core_cfg_pkg::word_t             ex_result_o
  , output core_cfg_pkg::word_t             ex_store_data_o
  , output core_cfg_pkg::flags_t            flags_o
  , output logic                            branch_o
  , output core_cfg_pkg::branch_target_t    branch_target_o
);

  localparam int RA_W = core_cfg_pkg::REG_ADDR_W;

  arm_isa_pkg::inst_class_e inst_class;
  arm_isa_pkg::alu_op_e     opcode;
  arm_isa_pkg::alu_op_e     alu_op;
  logic                     is_dp, is_ldst, is_branch, l_bit, is_compare;
  core_cfg_pkg::reg_addr_t  rn_addr, rd_addr, rs2_addr;
  core_cfg_pkg::word_t      rn_fwd, rs2_fwd, operand2, alu_result;
  logic                     cond_met, accept, write_d;
  logic                     ex_fwd;

  // ********************************************************
  // Decode
  // ********************************************************
  assign inst_class = arm_isa_pkg::inst_class_e'(inst_i[arm_isa_pkg::CLASS_LSB +: 3]);
  assign opcode     = arm_isa_pkg::alu_op_e'(inst_i[arm_isa_pkg::OPCODE_LSB +: 4]);
  assign is_dp      = inst_class == arm_isa_pkg::CLS_DP_REG ||
                      inst_class == arm_isa_pkg::CLS_DP_IMM;
  assign is_ldst    = inst_class == arm_isa_pkg::CLS_LDST;
  assign is_branch  = inst_class == arm_isa_pkg::CLS_BRANCH;
  // Bit 20 is S for data processing and L for load/store
  assign l_bit      = inst_i[arm_isa_pkg::S_BIT];
  // TST, TEQ, CMP, CMN
  assign is_compare = opcode[3:2] == 2'b10;

  assign rn_addr  = inst_i[arm_isa_pkg::RN_LSB +: RA_W];
  assign rd_addr  = inst_i[arm_isa_pkg::RD_LSB +: RA_W];
  // Second read port carries Rd as store data for load/store
  assign rs2_addr = is_ldst ? rd_addr : inst_i[arm_isa_pkg::RM_LSB +: RA_W];

  // ********************************************************
  // Forwarding from the execute output ahead of writeback
  // ********************************************************
  assign ex_fwd = ex_valid_o && ex_write_o && !ex_is_load_o;

  assign rn_fwd  = (ex_fwd && ex_rd_addr_o == rn_addr)  ? ex_result_o :
                   (wb_en_i && wb_addr_i == rn_addr)    ? wb_data_i : rn_data_i;
  assign rs2_fwd = (ex_fwd && ex_rd_addr_o == rs2_addr) ? ex_result_o :
                   (wb_en_i && wb_addr_i == rs2_addr)   ? wb_data_i : rm_data_i;

  // Load data only exists after writeback
  always_comb begin
    stall_o = 1'b0;
    if (valid_i && ex_valid_o && ex_is_load_o && ex_write_o) begin
      if ((is_dp || is_ldst) && rn_addr == ex_rd_addr_o) begin
        stall_o = 1'b1;
      end
      if ((inst_class == arm_isa_pkg::CLS_DP_REG || (is_ldst && !l_bit)) &&
          rs2_addr == ex_rd_addr_o) begin
        stall_o = 1'b1;
      end
    end
  end

  // Squash the slot behind a taken branch
  assign accept = valid_i && !stall_o && !branch_o;

  // Address generation adds or subtracts the offset by U
  assign alu_op = !is_ldst ? opcode :
                  inst_i[arm_isa_pkg::U_BIT] ? arm_isa_pkg::OP_ADD : arm_isa_pkg::OP_SUB;

  operand2_unit u_operand2 (
      .inst_i     (inst_i)
    , .rm_i       (rs2_fwd)
    , .operand2_o (operand2)
  );

  alu_core u_alu (
      .clk_i       (clk_i)
    , .reset_i     (reset_i)
    , .op_i        (alu_op)
    , .a_i         (rn_fwd)
    , .b_i         (operand2)
    , .cond_i      (arm_isa_pkg::cond_e'(inst_i[arm_isa_pkg::COND_LSB +: 4]))
    , .set_flags_i (is_dp && l_bit)
    , .update_i    (accept)
    , .result_o    (alu_result)
    , .cond_met_o  (cond_met)
    , .flags_o     (flags_o)
  );

  assign write_d = cond_met && ((is_dp && !is_compare) || (is_ldst && l_bit));

  // ********************************************************
  // Pipeline register
  // ********************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid_o    <= 1'b0;
      ex_write_o    <= 1'b0;
      ex_is_load_o  <= 1'b0;
      ex_is_store_o <= 1'b0;
      branch_o      <= 1'b0;
    end else begin
      ex_valid_o    <= accept;
      ex_write_o    <= accept && write_d;
      ex_is_load_o  <= accept && is_ldst && l_bit;
      ex_is_store_o <= accept && is_ldst && !l_bit && cond_met;
      branch_o      <= accept && is_branch && cond_met;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_rd_addr_o    <= rd_addr;
    ex_result_o     <= alu_result;
    ex_store_data_o <= rs2_fwd;
    branch_target_o <= inst_i[core_cfg_pkg::BRANCH_W-1:0];
  end

endmodule

`default_nettype wire

// File: hw/mem_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module mem_writeback #(
  parameter int MEM_WORDS = 16
) (
    input  wire                          clk_i
  , input  wire                          reset_i
  , input  wire                          ex_valid_i
  , input  wire                          ex_is_load_i
  , input  wire                          ex_is_store_i
  , input  wire                          ex_write_i
  , input  wire core_cfg_pkg::reg_addr_t ex_rd_addr_i
  , input  wire core_cfg_pkg::word_t     ex_result_i
  , input  wire core_cfg_pkg::word_t     ex_store_data_i
  , output logic                         wb_en_o
  , output core_cfg_pkg::reg_addr_t      wb_addr_o
  , output core_cfg_pkg::word_t          wb_data_o
);

  core_cfg_pkg::word_t       mem [MEM_WORDS];
  core_cfg_pkg::mem_addr_t   mem_idx;

  // Byte address from the ALU, drop the two low bits
  assign mem_idx = ex_result_i[2 +: core_cfg_pkg::MEM_ADDR_W];

  always_ff @(posedge clk_i) begin
    if (ex_valid_i && ex_is_store_i) begin
      mem[mem_idx] <= ex_store_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_en_o <= 1'b0;
    end else begin
      wb_en_o <= ex_valid_i && ex_write_i;
    end
  end

  // Load data or ALU result
  always_ff @(posedge clk_i) begin
    wb_addr_o <= ex_rd_addr_i;
    wb_data_o <= ex_is_load_i ? mem[mem_idx] : ex_result_i;
  end

endmodule

`default_nettype wire

// File: hw/exec_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_subsystem_top #(
    parameter int NUM_REGS  = 16
  , parameter int MEM_WORDS = 16
) (
    input  wire                             clk_i
  , input  wire                             reset_i
  , input  wire core_cfg_pkg::word_t        inst_i
  , input  wire                             issue_valid_i
  , output logic                            issue_stall_o
  , output logic                            wb_en_o
  , output core_cfg_pkg::reg_addr_t         wb_addr_o
  , output core_cfg_pkg::word_t             wb_data_o
  , output core_cfg_pkg::flags_t            flags_o
  , output logic                            branch_o
  , output core_cfg_pkg::branch_target_t    branch_target_o
);

  localparam int RA_W = core_cfg_pkg::REG_ADDR_W;

  core_cfg_pkg::reg_addr_t rs2_addr;
  core_cfg_pkg::word_t     rn_data, rm_data;
  logic                    ex_valid, ex_is_load, ex_is_store, ex_write;
  core_cfg_pkg::reg_addr_t ex_rd_addr;
  core_cfg_pkg::word_t     ex_result, ex_store_data;

  // Store data is read through the Rm port
  assign rs2_addr = (inst_i[arm_isa_pkg::CLASS_LSB +: 3] == arm_isa_pkg::CLS_LDST) ?
                    inst_i[arm_isa_pkg::RD_LSB +: RA_W] : inst_i[arm_isa_pkg::RM_LSB +: RA_W];

  register_file #(.NUM_REGS(NUM_REGS)) u_regfile (
      .clk_i      (clk_i)
    , .reset_i    (reset_i)
    , .rs1_addr_i (inst_i[arm_isa_pkg::RN_LSB +: RA_W])
    , .rs2_addr_i (rs2_addr)
    , .rs1_data_o (rn_data)
    , .rs2_data_o (rm_data)
    , .wr_en_i    (wb_en_o)
    , .wr_addr_i  (wb_addr_o)
    , .wr_data_i  (wb_data_o)
  );

  execute_stage u_execute (
      .clk_i           (clk_i)
    , .reset_i         (reset_i)
    , .inst_i          (inst_i)
    , .valid_i         (issue_valid_i)
    , .rn_data_i       (rn_data)
    , .rm_data_i       (rm_data)
    , .wb_en_i         (wb_en_o)
    , .wb_addr_i       (wb_addr_o)
    , .wb_data_i       (wb_data_o)
    , .stall_o         (issue_stall_o)
    , .ex_valid_o      (ex_valid)
    , .ex_is_load_o    (ex_is_load)
    , .ex_is_store_o   (ex_is_store)
    , .ex_write_o      (ex_write)
    , .ex_rd_addr_o    (ex_rd_addr)
    , .ex_result_o     (ex_result)
    , .ex_store_data_o (ex_store_data)
    , .flags_o         (flags_o)
    , .branch_o        (branch_o)
    , .branch_target_o (branch_target_o)
  );

  mem_writeback #(.MEM_WORDS(MEM_WORDS)) u_mem_wb (
      .clk_i           (clk_i)
    , .reset_i         (reset_i)
    , .ex_valid_i      (ex_valid)
    , .ex_is_load_i    (ex_is_load)
    , .ex_is_store_i   (ex_is_store)
    , .ex_write_i      (ex_write)
    , .ex_rd_addr_i    (ex_rd_addr)
    , .ex_result_i     (ex_result)
    , .ex_store_data_i (ex_store_data)
    , .wb_en_o         (wb_en_o)
    , .wb_addr_o       (wb_addr_o)
    , .wb_data_o       (wb_data_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_ref_model.svh
// ************************************************************
// Architectural state of the instruction subset
// ************************************************************
core_cfg_pkg::word_t          m_regs [16];
core_cfg_pkg::word_t          m_mem [16];
core_cfg_pkg::flags_t         m_flags;
logic                         m_branch_pending;
core_cfg_pkg::branch_target_t m_branch_target;
logic                         m_load_pending;
logic [3:0]                   m_load_rd;
// Expected register writes in retirement order
core_cfg_pkg::reg_addr_t      exp_addr_q [$];
core_cfg_pkg::word_t          exp_data_q [$];
logic [31:0]                  lfsr_state;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    val = {val[30:0], fb};
  end
  return val;
endfunction

function automatic void reset_model();
  for (int i = 0; i < 16; i++) begin
    m_regs[i] = '0;
    m_mem[i]  = '0;
  end
  m_flags          = '0;
  m_branch_pending = 1'b0;
  m_load_pending   = 1'b0;
  m_load_rd        = '0;
  m_branch_target  = '0;
endfunction

function automatic logic cond_holds(input logic [3:0] cond, input core_cfg_pkg::flags_t f);
  logic n, z, c, v;
  {n, z, c, v} = f;
  case (cond)
    4'h0: return z;
    4'h1: return !z;
    4'h2: return c;
    4'h3: return !c;
    4'h4: return n;
    4'h5: return !n;
    4'h6: return v;
    4'h7: return !v;
    4'h8: return c && !z;
    4'h9: return !c || z;
    4'hA: return n == v;
    4'hB: return n != v;
    4'hC: return !z && n == v;
    4'hD: return z || n != v;
    4'hE: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// Returns {carry, overflow, sum}
function automatic logic [33:0] add_with_carry(input core_cfg_pkg::word_t x,
                                               input core_cfg_pkg::word_t y,
                                               input logic cin);
  logic [32:0] unsigned_sum;
  logic [32:0] signed_sum;
  unsigned_sum = {1'b0, x} + {1'b0, y} + 33'(cin);
  signed_sum   = {x[31], x} + {y[31], y} + 33'(cin);
  return {unsigned_sum[32], signed_sum[32] ^ signed_sum[31], unsigned_sum[31:0]};
endfunction

function automatic core_cfg_pkg::word_t shift_operand(input core_cfg_pkg::word_t rm,
                                                      input logic [4:0] amt,
                                                      input logic [1:0] kind);
  case (kind)
    2'd0: return rm << amt;
    2'd1: return rm >> amt;
    2'd2: return core_cfg_pkg::word_t'($signed(rm) >>> amt);
    default: return (amt == 0) ? rm : (rm >> amt) | (rm << (32 - amt));
  endcase
endfunction

function automatic core_cfg_pkg::word_t rotate_immediate(input logic [7:0] imm,
                                                         input logic [3:0] rot);
  logic [4:0]          r;
  core_cfg_pkg::word_t w;
  r = {rot, 1'b0};
  w = {24'd0, imm};
  return (r == 0) ? w : (w >> r) | (w << (32 - r));
endfunction

function automatic void alu_reference(input logic [3:0] op,
                                      input core_cfg_pkg::word_t a,
                                      input core_cfg_pkg::word_t b,
                                      input core_cfg_pkg::flags_t f,
                                      output core_cfg_pkg::word_t res,
                                      output core_cfg_pkg::flags_t nf);
  logic [33:0] acv;
  logic        c, v;
  c   = f[1];
  v   = f[0];
  acv = '0;
  res = '0;
  case (op)
    4'h0, 4'h8: res = a & b;
    4'h1, 4'h9: res = a ^ b;
    4'h2, 4'hA: acv = add_with_carry(a, ~b, 1'b1);
    4'h3:       acv = add_with_carry(b, ~a, 1'b1);
    4'h4, 4'hB: acv = add_with_carry(a, b, 1'b0);
    4'h5:       acv = add_with_carry(a, b, c);
    4'h6:       acv = add_with_carry(a, ~b, c);
    4'h7:       acv = add_with_carry(b, ~a, c);
    4'hC:       res = a | b;
    4'hD:       res = b;
    4'hE:       res = a & ~b;
    default:    res = ~b;
  endcase
  // Arithmetic opcodes, logical ones keep C and V
  if ((op >= 4'h2 && op <= 4'h7) || op == 4'hA || op == 4'hB) begin
    {c, v, res} = acv;
  end
  nf = {res[31], res == '0, c, v};
endfunction

function automatic void write_reg(input logic [3:0] rd, input core_cfg_pkg::word_t data);
  m_regs[rd] = data;
  exp_addr_q.push_back(rd);
  exp_data_q.push_back(data);
endfunction

// Load in execute and the new instruction reads its destination
function automatic logic predict_stall(input core_cfg_pkg::word_t inst);
  logic [2:0] cls;
  logic       uses_rn, uses_rs2;
  logic [3:0] rs2;
  cls      = inst[27:25];
  uses_rn  = cls == 3'b000 || cls == 3'b001 || cls == 3'b010;
  // Rm for register operands, Rd as store data
  uses_rs2 = cls == 3'b000 || (cls == 3'b010 && !inst[20]);
  rs2      = (cls == 3'b010) ? inst[15:12] : inst[3:0];
  return m_load_pending && ((uses_rn && inst[19:16] == m_load_rd) ||
                            (uses_rs2 && rs2 == m_load_rd));
endfunction

function automatic void execute_reference(input core_cfg_pkg::word_t inst);
  logic [2:0]           cls;
  logic [3:0]           rn, rd;
  logic                 holds;
  core_cfg_pkg::word_t  b, res, addr;
  core_cfg_pkg::flags_t nf;
  cls   = inst[27:25];
  rn    = inst[19:16];
  rd    = inst[15:12];
  holds = cond_holds(inst[31:28], m_flags);
  m_branch_pending = 1'b0;
  m_load_pending   = 1'b0;
  if (holds && cls[2:1] == 2'b00) begin
    b = cls[0] ? rotate_immediate(inst[7:0], inst[11:8])
               : shift_operand(m_regs[inst[3:0]], inst[11:7], inst[6:5]);
    alu_reference(inst[24:21], m_regs[rn], b, m_flags, res, nf);
    // TST, TEQ, CMP and CMN only touch the flags
    if (inst[24:23] != 2'b10) begin
      write_reg(rd, res);
    end
    if (inst[20]) begin
      m_flags = nf;
    end
  end else if (holds && cls == 3'b010) begin
    addr = inst[23] ? m_regs[rn] + inst[11:0] : m_regs[rn] - inst[11:0];
    if (inst[20]) begin
      write_reg(rd, m_mem[addr[5:2]]);
      m_load_pending = 1'b1;
      m_load_rd      = rd;
    end else begin
      m_mem[addr[5:2]] = m_regs[rd];
    end
  end else if (holds && cls == 3'b101) begin
    m_branch_pending = 1'b1;
    m_branch_target  = inst[23:0];
  end
endfunction

// File: bench/tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top;

  localparam int NUM_INIT   = 32;
  localparam int NUM_RANDOM = 400;
  localparam int NUM_TOTAL  = NUM_INIT + NUM_RANDOM;
  localparam int CLK_PERIOD = 40;
  // Three cycles per instruction plus reset and drain
  localparam int WATCHDOG_CYCLES = 16 + 3 * NUM_TOTAL + 8;

  logic                         clk_i;
  logic                         reset_i;
  core_cfg_pkg::word_t          inst_i;
  logic                         issue_valid_i;
  logic                         issue_stall_o;
  logic                         wb_en_o;
  core_cfg_pkg::reg_addr_t      wb_addr_o;
  core_cfg_pkg::word_t          wb_data_o;
  core_cfg_pkg::flags_t         flags_o;
  logic                         branch_o;
  core_cfg_pkg::branch_target_t branch_target_o;
  core_cfg_pkg::reg_addr_t      wb_exp_addr;
  core_cfg_pkg::word_t          wb_exp_data;

  `include "tb_ref_model.svh"

  exec_subsystem_top #(
      .NUM_REGS  (16)
    , .MEM_WORDS (16)
  ) u_dut (
      .clk_i           (clk_i)
    , .reset_i         (reset_i)
    , .inst_i          (inst_i)
    , .issue_valid_i   (issue_valid_i)
    , .issue_stall_o   (issue_stall_o)
    , .wb_en_o         (wb_en_o)
    , .wb_addr_o       (wb_addr_o)
    , .wb_data_o       (wb_data_o)
    , .flags_o         (flags_o)
    , .branch_o        (branch_o)
    , .branch_target_o (branch_target_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, program did not complete", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

  // ************************************************************
  // Write checker samples mid-cycle while wb outputs are stable
  // ************************************************************
  always @(negedge clk_i) begin
    if (!reset_i && wb_en_o === 1'b1) begin
      assert (exp_addr_q.size() != 0) else begin
        $display("Unexpected register write to r%0d at %0t", wb_addr_o, $time);
        $display("TB FAILED");
        $fatal(1, "unexpected write");
      end
      wb_exp_addr = exp_addr_q.pop_front();
      wb_exp_data = exp_data_q.pop_front();
      assert (wb_addr_o === wb_exp_addr) else begin
        $display("MISMATCH t=%0t wb_addr_o got %0d expected %0d",
                 $time, wb_addr_o, wb_exp_addr);
        $display("TB FAILED");
        $fatal(1, "write address");
      end
      assert (wb_data_o === wb_exp_data) else begin
        $display("MISMATCH t=%0t wb_data_o got %h expected %h",
                 $time, wb_data_o, wb_exp_data);
        $display("TB FAILED");
        $fatal(1, "write data");
      end
    end
  end

  function automatic core_cfg_pkg::word_t gen_instruction();
    logic [3:0] cond, op, rn, rd, rm, rot, word;
    logic [2:0] kind;
    logic [4:0] amt;
    logic [1:0] sh;
    logic [7:0] imm;
    logic       s, u, l;
    // Half the instructions unconditional
    cond = (rand_bits(1) != 0) ? 4'hE : 4'(rand_bits(4));
    kind = 3'(rand_bits(3));
    op   = 4'(rand_bits(4));
    // Compares always set flags
    s    = (rand_bits(1) != 0) || op[3:2] == 2'b10;
    // Eight registers keep dependencies frequent
    rn   = 4'(rand_bits(3));
    rd   = 4'(rand_bits(3));
    rm   = 4'(rand_bits(3));
    amt  = 5'(rand_bits(5));
    sh   = 2'(rand_bits(2));
    rot  = 4'(rand_bits(4));
    imm  = 8'(rand_bits(8));
    u    = rand_bits(1) != 0;
    l    = rand_bits(1) != 0;
    word = 4'(rand_bits(4));
    if (kind < 3) begin
      return {cond, 3'b000, op, s, rn, rd, amt, sh, 1'b0, rm};
    end else if (kind < 5) begin
      return {cond, 3'b001, op, s, rn, rd, rot, imm};
    end else if (kind < 7) begin
      // Word offset below 64 bytes
      return {cond, 3'b010, 1'b1, u, 2'b00, l, rn, rd, 6'd0, word, 2'b00};
    end
    return {cond, 3'b101, 1'b0, 24'(rand_bits(24))};
  endfunction

  // One issue cycle entered 2 ns after a rising edge
  task automatic run_cycle(input logic valid, input core_cfg_pkg::word_t inst,
                           output logic accepted);
    logic exp_stall;
    inst_i        = inst;
    issue_valid_i = valid;
    exp_stall     = valid && predict_stall(inst);
    @(negedge clk_i);
    assert (issue_stall_o === exp_stall) else begin
      $display("MISMATCH t=%0t issue_stall_o got %b expected %b",
               $time, issue_stall_o, exp_stall);
      $display("TB FAILED");
      $fatal(1, "stall");
    end
    assert (flags_o === m_flags) else begin
      $display("MISMATCH t=%0t flags_o got %h expected %h", $time, flags_o, m_flags);
      $display("TB FAILED");
      $fatal(1, "flags");
    end
    assert (branch_o === m_branch_pending) else begin
      $display("MISMATCH t=%0t branch_o got %b expected %b",
               $time, branch_o, m_branch_pending);
      $display("TB FAILED");
      $fatal(1, "branch");
    end
    if (m_branch_pending) begin
      assert (branch_target_o === m_branch_target) else begin
        $display("MISMATCH t=%0t branch_target_o got %h expected %h",
                 $time, branch_target_o, m_branch_target);
        $display("TB FAILED");
        $fatal(1, "branch target");
      end
    end
    @(posedge clk_i);
    accepted = valid && !exp_stall;
    if (accepted && !m_branch_pending) begin
      execute_reference(inst);
    end else begin
      // Bubble, stall or squashed slot
      m_branch_pending = 1'b0;
      m_load_pending   = 1'b0;
    end
    #2;
  endtask

  // ************************************************************
  // Reset, program issue and final check
  // ************************************************************
  initial begin
    logic                accepted;
    core_cfg_pkg::word_t inst;
    reset_i       = 1'b1;
    issue_valid_i = 1'b0;
    inst_i        = '0;
    lfsr_state    = 32'head3edfa;
    reset_model();
    repeat (16) @(posedge clk_i);
    #2;
    assert (!wb_en_o && !branch_o && !issue_stall_o && flags_o == '0) else begin
      $display("Outputs not cleared by reset at %0t", $time);
      $display("TB FAILED");
      $fatal(1, "reset state");
    end
    reset_i = 1'b0;
    for (int n = 0; n < NUM_TOTAL; n++) begin
      if (n < NUM_INIT) begin
        // Pairs of ADD r0 and STR r0 to [r1] leave k + 1 in memory word k
        if (n % 2 == 0) begin
          inst = {4'hE, 3'b001, 4'h4, 1'b0, 4'd0, 4'd0, 4'd0, 8'd1};
        end else begin
          inst = {4'hE, 3'b010, 1'b1, 1'b1, 2'b00, 1'b0, 4'd1, 4'd0, 6'd0, 4'(n / 2), 2'b00};
        end
      end else begin
        if (rand_bits(3) == 0) begin
          run_cycle(1'b0, '0, accepted);
        end
        inst = gen_instruction();
      end
      accepted = 1'b0;
      while (!accepted) begin
        run_cycle(1'b1, inst, accepted);
      end
    end
    issue_valid_i = 1'b0;
    // A write retires two edges after its instruction is accepted
    repeat (4) @(posedge clk_i);
    if (exp_addr_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("%0d expected register writes never appeared", exp_addr_q.size());
      $display("TB FAILED");
      $fatal(1, "leftover writes");
    end
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+bench
hw/core_cfg_pkg.sv
hw/arm_isa_pkg.sv
hw/register_file.sv
hw/operand2_unit.sv
hw/alu_core.sv
hw/execute_stage.sv
hw/mem_writeback.sv
hw/exec_subsystem_top.sv
bench/tb_exec_top.sv

// File: Bender.yml
package:
  name: exec_subsystem

sources:
  - files:
      - hw/core_cfg_pkg.sv
      - hw/arm_isa_pkg.sv
      - hw/register_file.sv
      - hw/operand2_unit.sv
      - hw/alu_core.sv
      - hw/execute_stage.sv
      - hw/mem_writeback.sv
      - hw/exec_subsystem_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_exec_top.sv
